// File: files.f
logic/e_rr_pkg.sv
logic/e_grant_if.sv
logic/e_route_compare.sv
logic/e_rr_order.sv
logic/e_credit_counter.sv
logic/e_grant_select.sv
logic/e_output_crossbar.sv
logic/e_rr_processor_top.sv
verification/e_rr_processor_tb.sv

// File: Bender.yml
package:
  name: e_rr_processor

sources:
  - logic/e_rr_pkg.sv
  - logic/e_grant_if.sv
  - logic/e_route_compare.sv
  - logic/e_rr_order.sv
  - logic/e_credit_counter.sv
  - logic/e_grant_select.sv
  - logic/e_output_crossbar.sv
  - logic/e_rr_processor_top.sv
  - target: test
    files:
      - verification/e_rr_processor_tb.sv

// File: verification/e_rr_processor_tb.sv
`timescale 1ns/1ps

module e_rr_processor_tb;
  import e_rr_pkg::*;

  logic              clk;
  logic              reset_i;
  // index 0..3 is N, S, W, L
  logic [2:0]        nexthop [4];
  logic [FLIT_W-1:0] flit [4];
  logic              change_order_i;
  logic              credit_return_i;
  logic              grant_n_o;
  logic              grant_s_o;
  logic              grant_w_o;
  logic              grant_l_o;
  logic [2:0]        cs_sel_o;
  logic [FLIT_W-1:0] flit_o;
  logic              flit_valid_o;

  // pipeline model, one set of registers per stage
  logic [3:0]        m_req;
  logic [FLIT_W-1:0] m_f1 [4];
  logic [3:0]        m_grant;
  logic [2:0]        m_sel;
  int                m_gport;
  logic [FLIT_W-1:0] m_f2 [4];
  logic              m_fvalid;
  logic [FLIT_W-1:0] m_flit;
  logic              m_flit_known;
  int                m_order;
  int                m_cnt;
  logic [3:0]        last_grant;

  e_rr_processor_top DUT (
    .clk             (clk),
    .reset_i         (reset_i),
    .n_nexthop_i     (nexthop[0]),
    .s_nexthop_i     (nexthop[1]),
    .w_nexthop_i     (nexthop[2]),
    .l_nexthop_i     (nexthop[3]),
    .n_flit_i        (flit[0]),
    .s_flit_i        (flit[1]),
    .w_flit_i        (flit[2]),
    .l_flit_i        (flit[3]),
    .change_order_i  (change_order_i),
    .credit_return_i (credit_return_i),
    .grant_n_o       (grant_n_o),
    .grant_s_o       (grant_s_o),
    .grant_w_o       (grant_w_o),
    .grant_l_o       (grant_l_o),
    .cs_sel_o        (cs_sel_o),
    .flit_o          (flit_o),
    .flit_valid_o    (flit_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  function automatic logic [2:0] port_code(int p);
    return (p == 3) ? 3'(DIR_L) : 3'(p);
  endfunction

  function automatic logic one_in(int n);
    return ($urandom_range(0, n - 1) == 0);
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic model_reset();
    m_req        = '0;
    m_grant      = '0;
    m_sel        = IDLE_SEL;
    m_gport      = 0;
    m_fvalid     = 1'b0;
    m_flit_known = 1'b0;
    m_order      = 0;
    m_cnt        = CREDIT_MAX;
    last_grant   = '0;
    for (int p = 0; p < 4; p++) begin
      m_f1[p] = '0;
      m_f2[p] = '0;
    end
  endtask

  // advance the model by one edge with the inputs that were just sampled
  task automatic model_step();
    logic [3:0] g;
    logic [2:0] s;
    int         hit;
    int         p;
    g   = '0;
    s   = IDLE_SEL;
    hit = 0;
    if (m_cnt > 0) begin
      for (int k = 0; k < 4; k++) begin
        p = (m_order + k) % 4;
        if (g == '0 && m_req[3-p]) begin
          g[3-p] = 1'b1;
          s      = port_code(p);
          hit    = p;
        end
      end
    end
    if (|m_grant) begin
      m_flit       = m_f2[m_gport];
      m_flit_known = 1'b1;
    end
    m_fvalid = |m_grant;
    m_cnt    = m_cnt - int'(|g) + int'(credit_return_i);
    m_grant  = g;
    m_sel    = s;
    m_gport  = hit;
    m_f2     = m_f1;
    m_f1     = flit;
    for (int q = 0; q < 4; q++) begin
      m_req[3-q] = (nexthop[q] == DIR_E);
    end
    if (change_order_i) begin
      m_order = (m_order + 1) % 4;
    end
  endtask

  task automatic compare_outputs(input logic [3:0] req_before);
    logic [3:0] g;
    g = {grant_n_o, grant_s_o, grant_w_o, grant_l_o};
    check_value((g & (g - 4'd1)) == 4'd0, 1, "grant not one-hot");
    check_value(g & ~req_before, 0, "grant without east request");
    check_value(flit_valid_o, |last_grant, "flit_valid_o one cycle after grant");
    check_value(g, m_grant, "grant vector");
    check_value(cs_sel_o, m_sel, "cs_sel_o");
    check_value(flit_valid_o, m_fvalid, "flit_valid_o");
    if (m_flit_known) begin
      check_value(flit_o, m_flit, "flit_o");
    end
  endtask

  task automatic clock_cycle();
    logic [3:0] req_before;
    @(posedge clk);
    #2;
    req_before = m_req;
    model_step();
    compare_outputs(req_before);
    last_grant = {grant_n_o, grant_s_o, grant_w_o, grant_l_o};
  endtask

  task automatic drive_inputs(input logic [3:0] east_mask, input logic chg,
                              input logic ret_wanted);
    for (int p = 0; p < 4; p++) begin
      nexthop[p] = east_mask[3-p] ? 3'(DIR_E) : port_code($urandom_range(0, 3));
      flit[p]    = FLIT_W'($urandom);
    end
    change_order_i  = chg;
    // only slots that are in use downstream can come back
    credit_return_i = ret_wanted && (m_cnt < CREDIT_MAX);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (!(m_cnt == CREDIT_MAX && m_grant == '0 && m_req == '0 && !flit_valid_o)) begin
      if (n == 32) begin
        $display("pipeline did not go idle within 32 cycles");
        $display("Test failures found");
        $fatal(1, "drain timeout");
      end
      drive_inputs(4'b0000, 1'b0, 1'b1);
      clock_cycle();
      n++;
    end
  endtask

  initial begin
    int n;
    void'($urandom(23));
    reset_i         = 1'b1;
    change_order_i  = 1'b0;
    credit_return_i = 1'b0;
    for (int p = 0; p < 4; p++) begin
      nexthop[p] = DIR_N;
      flit[p]    = '0;
    end
    model_reset();
    repeat (8) @(posedge clk);
    #2;
    reset_i = 1'b0;

    // idle after reset, nobody names east
    for (int i = 0; i < 20; i++) begin
      drive_inputs(4'b0000, 1'b0, 1'b0);
      clock_cycle();
    end

    // route decode
    for (int i = 0; i < 200; i++) begin
      drive_inputs(4'($urandom_range(0, 15)), 1'b0, one_in(2));
      clock_cycle();
    end
    drain();

    // round robin, everyone asks
    for (int i = 0; i < 200; i++) begin
      drive_inputs(4'hF, one_in(4), 1'b1);
      clock_cycle();
    end
    drain();

    // back-pressure, steady requests and no returns
    n = 0;
    for (int i = 0; i < 40; i++) begin
      drive_inputs(4'hF, 1'b0, 1'b0);
      clock_cycle();
      if (last_grant != '0) n++;
    end
    check_value(n, CREDIT_MAX, "grants without credit return");
    for (int i = 0; i < 8; i++) begin
      drive_inputs(4'h0, 1'b0, 1'b1);
      clock_cycle();
    end
    n = 0;
    for (int i = 0; i < 12; i++) begin
      drive_inputs((i % 3 == 0) ? 4'hF : 4'h0, 1'b0, 1'b0);
      clock_cycle();
      if (last_grant != '0) n++;
    end
    check_value(n > 0, 1, "grants resume after returns");
    drain();

    // data path, one east input per cycle
    n = 0;
    for (int i = 0; i < 200; i++) begin
      drive_inputs(4'(1 << $urandom_range(0, 3)), one_in(4), 1'b1);
      clock_cycle();
      if (flit_valid_o) n++;
    end
    check_value(n > 100, 1, "flits forwarded in data path test");
    drain();

    // random mix
    for (int i = 0; i < 2000; i++) begin
      drive_inputs(4'($urandom_range(0, 15)), one_in(3), one_in(2));
      clock_cycle();
    end
    drain();

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: logic/e_rr_processor_top.sv
`timescale 1ns/1ps

module e_rr_processor_top (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic [2:0]                    n_nexthop_i,
  input  logic [2:0]                    s_nexthop_i,
  input  logic [2:0]                    w_nexthop_i,
  input  logic [2:0]                    l_nexthop_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   n_flit_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   s_flit_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   w_flit_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   l_flit_i,
  input  logic                          change_order_i,
  input  logic                          credit_return_i,
  output logic                          grant_n_o,
  output logic                          grant_s_o,
  output logic                          grant_w_o,
  output logic                          grant_l_o,
  output logic [2:0]                    cs_sel_o,
  output logic [e_rr_pkg::FLIT_W-1:0]   flit_o,
  output logic                          flit_valid_o
);
  import e_rr_pkg::*;

  logic [3:0]        req_q;
  logic [FLIT_W-1:0] n_flit_q;
  logic [FLIT_W-1:0] s_flit_q;
  logic [FLIT_W-1:0] w_flit_q;
  logic [FLIT_W-1:0] l_flit_q;
  in_port_e          order;
  logic              credit_avail;

  e_grant_if gnt_if ();

  e_route_compare u_route_compare (
    .clk         (clk),
    .reset_i     (reset_i),
    .n_nexthop_i (dir_e'(n_nexthop_i)),
    .s_nexthop_i (dir_e'(s_nexthop_i)),
    .w_nexthop_i (dir_e'(w_nexthop_i)),
    .l_nexthop_i (dir_e'(l_nexthop_i)),
    .n_flit_i    (n_flit_i),
    .s_flit_i    (s_flit_i),
    .w_flit_i    (w_flit_i),
    .l_flit_i    (l_flit_i),
    .req_o       (req_q),
    .n_flit_o    (n_flit_q),
    .s_flit_o    (s_flit_q),
    .w_flit_o    (w_flit_q),
    .l_flit_o    (l_flit_q)
  );

  e_rr_order u_rr_order (
    .clk            (clk),
    .reset_i        (reset_i),
    .change_order_i (change_order_i),
    .order_o        (order)
  );

  e_credit_counter u_credit_counter (
    .clk             (clk),
    .reset_i         (reset_i),
    .take_i          (gnt_if.grant_valid),
    .credit_return_i (credit_return_i),
    .credit_avail_o  (credit_avail)
  );

  e_grant_select u_grant_select (
    .clk            (clk),
    .reset_i        (reset_i),
    .req_i          (req_q),
    .n_flit_i       (n_flit_q),
    .s_flit_i       (s_flit_q),
    .w_flit_i       (w_flit_q),
    .l_flit_i       (l_flit_q),
    .order_i        (order),
    .credit_avail_i (credit_avail),
    .gnt            (gnt_if)
  );

  e_output_crossbar u_output_crossbar (
    .clk          (clk),
    .reset_i      (reset_i),
    .gnt          (gnt_if),
    .flit_o       (flit_o),
    .flit_valid_o (flit_valid_o)
  );

  assign grant_n_o = gnt_if.grant[REQ_N_BIT];
  assign grant_s_o = gnt_if.grant[REQ_S_BIT];
  assign grant_w_o = gnt_if.grant[REQ_W_BIT];
  assign grant_l_o = gnt_if.grant[REQ_L_BIT];
  assign cs_sel_o  = gnt_if.cs_sel;

endmodule

// File: logic/e_output_crossbar.sv
`timescale 1ns/1ps

module e_output_crossbar (
  input  logic                          clk,
  input  logic                          reset_i,
  e_grant_if.dst                        gnt,
  output logic [e_rr_pkg::FLIT_W-1:0]   flit_o,
  output logic                          flit_valid_o
);
  import e_rr_pkg::*;

  logic [FLIT_W-1:0] flit_mux;

  always_comb begin
    case (gnt.cs_sel)
      DIR_N:   flit_mux = gnt.n_flit;
      DIR_S:   flit_mux = gnt.s_flit;
      DIR_W:   flit_mux = gnt.w_flit;
      DIR_L:   flit_mux = gnt.l_flit;
      default: flit_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      flit_valid_o <= 1'b0;
    end else begin
      flit_valid_o <= gnt.grant_valid;
    end
  end

  // last flit stays on the link while idle
  always_ff @(posedge clk) begin
    if (gnt.grant_valid) begin
      flit_o <= flit_mux;
    end
  end

  // a live grant never selects the idle east code
  a_sel_not_idle: assert property (
    @(posedge clk) disable iff (reset_i)
      gnt.grant_valid |-> (gnt.cs_sel != IDLE_SEL)
  );

endmodule

// File: logic/e_grant_select.sv
`timescale 1ns/1ps

module e_grant_select (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic [3:0]                    req_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   n_flit_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   s_flit_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   w_flit_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   l_flit_i,
  input  e_rr_pkg::in_port_e            order_i,
  input  logic                          credit_avail_i,
  e_grant_if.src                        gnt
);
  import e_rr_pkg::*;

  function automatic int port_bit(in_port_e p);
    case (p)
      PORT_N:  return REQ_N_BIT;
      PORT_S:  return REQ_S_BIT;
      PORT_W:  return REQ_W_BIT;
      default: return REQ_L_BIT;
    endcase
  endfunction

  function automatic dir_e port_dir(in_port_e p);
    case (p)
      PORT_N:  return DIR_N;
      PORT_S:  return DIR_S;
      PORT_W:  return DIR_W;
      default: return DIR_L;
    endcase
  endfunction

  logic       req_hit;
  in_port_e   hit_port;
  in_port_e   scan_port;
  logic [3:0] grant_d;
  dir_e       sel_d;

  // walk the four inputs starting at the pointer, first request wins
  always_comb begin
    req_hit   = 1'b0;
    hit_port  = order_i;
    scan_port = order_i;
    for (int k = 0; k < 4; k++) begin
      if (!req_hit && req_i[port_bit(scan_port)]) begin
        req_hit  = 1'b1;
        hit_port = scan_port;
      end
      scan_port = in_port_e'(scan_port + 2'd1);
    end
  end

  // no credit means the request is dropped this cycle
  always_comb begin
    grant_d = '0;
    sel_d   = IDLE_SEL;
    if (req_hit && credit_avail_i) begin
      grant_d[port_bit(hit_port)] = 1'b1;
      sel_d                       = port_dir(hit_port);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      gnt.grant       <= '0;
      gnt.cs_sel      <= IDLE_SEL;
      gnt.grant_valid <= 1'b0;
    end else begin
      gnt.grant       <= grant_d;
      gnt.cs_sel      <= sel_d;
      gnt.grant_valid <= |grant_d;
    end
  end

  always_ff @(posedge clk) begin
    gnt.n_flit <= n_flit_i;
    gnt.s_flit <= s_flit_i;
    gnt.w_flit <= w_flit_i;
    gnt.l_flit <= l_flit_i;
  end

  a_grant_onehot: assert property (
    @(posedge clk) disable iff (reset_i)
      $onehot0(gnt.grant)
  );

endmodule

// File: logic/e_credit_counter.sv
`timescale 1ns/1ps

module e_credit_counter (
  input  logic clk,
  input  logic reset_i,
  input  logic take_i,
  input  logic credit_return_i,
  output logic credit_avail_o
);
  import e_rr_pkg::*;

  logic [CREDIT_W-1:0] count_q;

  // buffer starts empty, so all slots are free
  always_ff @(posedge clk) begin
    if (reset_i) begin
      count_q <= CREDIT_W'(CREDIT_MAX);
    end else begin
      unique case ({take_i, credit_return_i})
        2'b10:   count_q <= count_q - 1'b1;
        2'b01:   count_q <= count_q + 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // a grant still sitting in the grant register has spent its credit already
  assign credit_avail_o = (count_q > CREDIT_W'(take_i));

  // downstream cannot return more slots than it has
  a_count_max: assert property (
    @(posedge clk) disable iff (reset_i)
      count_q <= CREDIT_W'(CREDIT_MAX)
  );

  // grant stage must hold off at zero credits
  a_no_take_empty: assert property (
    @(posedge clk) disable iff (reset_i)
      take_i |-> (count_q != '0)
  );

endmodule

// File: logic/e_rr_order.sv
`timescale 1ns/1ps

module e_rr_order (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 change_order_i,
  output e_rr_pkg::in_port_e   order_o
);
  import e_rr_pkg::*;

  in_port_e order_q;
  in_port_e order_next;

  // N -> S -> W -> L -> N
  always_comb begin
    unique case (order_q)
      PORT_N:  order_next = PORT_S;
      PORT_S:  order_next = PORT_W;
      PORT_W:  order_next = PORT_L;
      PORT_L:  order_next = PORT_N;
      default: order_next = PORT_N;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      order_q <= PORT_N;
    end else if (change_order_i) begin
      order_q <= order_next;
    end
  end

  // head of the priority list
  assign order_o = order_q;

endmodule

// File: logic/e_route_compare.sv
`timescale 1ns/1ps

module e_route_compare (
  input  logic                          clk,
  input  logic                          reset_i,
  input  e_rr_pkg::dir_e                n_nexthop_i,
  input  e_rr_pkg::dir_e                s_nexthop_i,
  input  e_rr_pkg::dir_e                w_nexthop_i,
  input  e_rr_pkg::dir_e                l_nexthop_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   n_flit_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   s_flit_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   w_flit_i,
  input  logic [e_rr_pkg::FLIT_W-1:0]   l_flit_i,
  output logic [3:0]                    req_o,
  output logic [e_rr_pkg::FLIT_W-1:0]   n_flit_o,
  output logic [e_rr_pkg::FLIT_W-1:0]   s_flit_o,
  output logic [e_rr_pkg::FLIT_W-1:0]   w_flit_o,
  output logic [e_rr_pkg::FLIT_W-1:0]   l_flit_o
);
  import e_rr_pkg::*;

  // an input wants east when its next hop names east
  always_ff @(posedge clk) begin
    if (reset_i) begin
      req_o <= '0;
    end else begin
      req_o[REQ_N_BIT] <= (n_nexthop_i == DIR_E);
      req_o[REQ_S_BIT] <= (s_nexthop_i == DIR_E);
      req_o[REQ_W_BIT] <= (w_nexthop_i == DIR_E);
      req_o[REQ_L_BIT] <= (l_nexthop_i == DIR_E);
    end
  end

  always_ff @(posedge clk) begin
    n_flit_o <= n_flit_i;
    s_flit_o <= s_flit_i;
    w_flit_o <= w_flit_i;
    l_flit_o <= l_flit_i;
  end

  // codes 5..7 never come out of the routing stage
  property p_legal_code(logic [2:0] code);
    @(posedge clk) disable iff (reset_i)
      code inside {DIR_N, DIR_S, DIR_W, DIR_E, DIR_L};
  endproperty

  a_n_code: assert property (p_legal_code(n_nexthop_i));
  a_s_code: assert property (p_legal_code(s_nexthop_i));
  a_w_code: assert property (p_legal_code(w_nexthop_i));
  a_l_code: assert property (p_legal_code(l_nexthop_i));

endmodule

// File: logic/e_grant_if.sv
`timescale 1ns/1ps

interface e_grant_if;
  import e_rr_pkg::*;

  logic [3:0]        grant;
  dir_e              cs_sel;
  logic              grant_valid;
  // flits travel alongside the grant so the crossbar sees the matching cycle
  logic [FLIT_W-1:0] n_flit;
  logic [FLIT_W-1:0] s_flit;
  logic [FLIT_W-1:0] w_flit;
  logic [FLIT_W-1:0] l_flit;

  modport src (
    output grant, cs_sel, grant_valid,
    output n_flit, s_flit, w_flit, l_flit
  );

  modport dst (
    input grant, cs_sel, grant_valid,
    input n_flit, s_flit, w_flit, l_flit
  );

endinterface

// File: logic/e_rr_pkg.sv
package e_rr_pkg;

  // next-hop direction codes, shared by the route compare and crossbar select
  typedef enum logic [2:0] {
    DIR_N = 3'd0,
    DIR_S = 3'd1,
    DIR_W = 3'd2,
    DIR_E = 3'd3,
    DIR_L = 3'd4
  } dir_e;

  // round-robin pointer, listed in rotation order
  typedef enum logic [1:0] {
    PORT_N = 2'd0,
    PORT_S = 2'd1,
    PORT_W = 2'd2,
    PORT_L = 2'd3
  } in_port_e;

  localparam int FLIT_W = 16;

  // depth of the downstream east buffer
  localparam int CREDIT_MAX = 4;
  localparam int CREDIT_W   = 3;

  // crossbar select when nothing is granted
  localparam dir_e IDLE_SEL = DIR_E;

  // bit positions in the request and grant vectors
  localparam int REQ_N_BIT = 3;
  localparam int REQ_S_BIT = 2;
  localparam int REQ_W_BIT = 1;
  localparam int REQ_L_BIT = 0;

endpackage
